// ==== hdl/l1d_ctrl.sv ====
/*
  l1d controller: accepts LSU requests, answers hits, parks misses in
  the MSHRs, installs refills, writes back dirty victims and replays
*/
`timescale 1ns/10ps

module l1d_ctrl import l1d_pkg::*; (
  input  logic                 clk_in,
  input  logic                 rst_N_in,
  input  lsu_req_t             lsu_req,
  input  logic                 lsu_req_valid,
  output logic                 lsu_req_ready,
  output lsu_rsp_t             lsu_rsp,
  output logic                 lsu_rsp_valid,
  input  logic                 lsu_rsp_ready,
  output lc_req_t              lc_req,
  output logic                 lc_req_valid,
  input  logic                 lc_req_ready,
  input  lc_rsp_t              lc_rsp,
  input  logic                 lc_rsp_valid,
  output logic                 lc_rsp_ready,
  // array and MSHR file
  output block_addr_t          lookup_addr,
  output word_sel_t            lookup_word,
  output logic                 wr_en,
  output logic [WORD_BITS-1:0] wr_data,
  output logic                 fill_en,
  output logic [LINE_BITS-1:0] fill_line,
  output logic                 push_en,
  output mshr_op_t             push_op,
  output logic                 pop_en,
  input  logic                 arr_hit,
  input  logic [WORD_BITS-1:0] arr_word,
  input  logic                 victim_valid_dirty,
  input  block_addr_t          victim_addr,
  input  logic [LINE_BITS-1:0] victim_line,
  input  logic                 mshr_match,
  input  logic                 mshr_match_full,
  input  logic                 mshr_free,
  input  mshr_op_t             mshr_head,
  input  logic                 mshr_head_valid
);

  ctrl_state_t state_q, state_d;
  lsu_rsp_t    rsp_q, rsp_d;
  lc_req_t     lc_req_q, lc_req_d;
  block_addr_t refill_blk_q;
  logic        rsp_load;
  logic        lc_load;

  assign lsu_rsp       = rsp_q;
  assign lc_req        = lc_req_q;
  assign lsu_rsp_valid = (state_q == RESPOND) || (state_q == REPLAY_RESPOND);
  assign lc_req_valid  = (state_q == REQ_LINE) || (state_q == WRITEBACK);

  // the queued form of the presented request
  assign push_op = '{tag: lsu_req.tag, word: word_of(lsu_req.addr), we: lsu_req.we,
                     data: lsu_req.data};

  always_comb begin
    state_d       = state_q;
    lookup_addr   = refill_blk_q;
    lookup_word   = mshr_head.word;
    wr_en         = 1'b0;
    wr_data       = mshr_head.data;
    fill_en       = 1'b0;
    fill_line     = lc_rsp.line;
    push_en       = 1'b0;
    pop_en        = 1'b0;
    lsu_req_ready = 1'b0;
    lc_rsp_ready  = 1'b0;
    rsp_load      = 1'b0;
    rsp_d         = rsp_q;
    lc_load       = 1'b0;
    lc_req_d      = lc_req_q;

    case (state_q)
      IDLE: begin
        lookup_word = word_of(lsu_req.addr);
        wr_data     = lsu_req.data;
        if (lc_rsp_valid) begin
          // refills win over new requests; the victim is read before the fill lands
          lookup_addr  = lc_rsp.addr;
          lc_rsp_ready = 1'b1;
          fill_en      = 1'b1;
          if (victim_valid_dirty) begin
            lc_load  = 1'b1;
            lc_req_d = '{addr: victim_addr, we: 1'b1, line: victim_line};
            state_d  = WRITEBACK;
          end else begin
            state_d = REPLAY;
          end
        end else begin
          lookup_addr   = blk_of(lsu_req.addr);
          lsu_req_ready = lsu_req_valid &&
                          (arr_hit || (mshr_match && !mshr_match_full) ||
                           (!mshr_match && mshr_free));
          if (lsu_req_valid && lsu_req_ready) begin
            if (arr_hit) begin
              wr_en    = lsu_req.we;
              rsp_load = 1'b1;
              rsp_d    = '{tag: lsu_req.tag, we: lsu_req.we,
                           data: lsu_req.we ? WORD_BITS'(0) : arr_word};
              state_d  = RESPOND;
            end else begin
              push_en = 1'b1;
              // only a primary miss asks the lower level for the block
              if (!mshr_match) begin
                lc_load  = 1'b1;
                lc_req_d = '{addr: blk_of(lsu_req.addr), we: 1'b0, line: LINE_BITS'(0)};
                state_d  = REQ_LINE;
              end
            end
          end
        end
      end

      RESPOND: begin
        if (lsu_rsp_ready) state_d = IDLE;
      end

      REQ_LINE: begin
        if (lc_req_ready) state_d = IDLE;
      end

      WRITEBACK: begin
        if (lc_req_ready) state_d = REPLAY;
      end

      REPLAY: begin
        // drain the refilled block's queue, oldest first
        if (mshr_head_valid) begin
          pop_en   = 1'b1;
          wr_en    = mshr_head.we;
          rsp_load = 1'b1;
          rsp_d    = '{tag: mshr_head.tag, we: mshr_head.we,
                       data: mshr_head.we ? WORD_BITS'(0) : arr_word};
          state_d  = REPLAY_RESPOND;
        end else begin
          state_d = IDLE;
        end
      end

      REPLAY_RESPOND: begin
        if (lsu_rsp_ready) state_d = REPLAY;
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rsp_load) rsp_q <= rsp_d;
    if (lc_load) lc_req_q <= lc_req_d;
    if (fill_en) refill_blk_q <= lc_rsp.addr;
  end

  // response must not change while the LSU stalls it
  a_rsp_stable: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    lsu_rsp_valid && !lsu_rsp_ready |=> lsu_rsp_valid && $stable(lsu_rsp));

endmodule

// ==== hdl/l1d_data_array.sv ====
/*
  l1d data array: direct-mapped tag, valid, dirty and line storage with
  combinational lookup, word write and whole-line fill
*/
`timescale 1ns/10ps

module l1d_data_array import l1d_pkg::*; (
  input  logic                 clk_in,
  input  logic                 rst_N_in,
  input  block_addr_t          lookup_addr,
  input  word_sel_t            lookup_word,
  output logic                 arr_hit,
  output logic [WORD_BITS-1:0] arr_word,
  input  logic                 wr_en,
  input  logic [WORD_BITS-1:0] wr_data,
  input  logic                 fill_en,
  input  logic [LINE_BITS-1:0] fill_line,
  output logic                 victim_valid_dirty,
  output block_addr_t          victim_addr,
  output logic [LINE_BITS-1:0] victim_line
);

  logic [TAG_BITS-1:0]                      tag_q [NUM_SETS];
  logic [WORDS_PER_LINE-1:0][WORD_BITS-1:0] line_q [NUM_SETS];
  logic [NUM_SETS-1:0]                      valid_q;
  logic [NUM_SETS-1:0]                      dirty_q;

  logic [INDEX_BITS-1:0] idx;
  logic [TAG_BITS-1:0]   tag;

  assign idx = lookup_addr[INDEX_BITS-1:0];
  assign tag = lookup_addr[INDEX_BITS +: TAG_BITS];

  assign arr_hit  = valid_q[idx] && (tag_q[idx] == tag);
  assign arr_word = line_q[idx][lookup_word];

  // current occupant of the set, seen before any fill replaces it
  assign victim_valid_dirty = valid_q[idx] && dirty_q[idx];
  assign victim_addr        = {tag_q[idx], idx};
  assign victim_line        = line_q[idx];

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (fill_en) begin
      valid_q[idx] <= 1'b1;
      dirty_q[idx] <= 1'b0;
    end else if (wr_en) begin
      dirty_q[idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_in) begin
    if (fill_en) begin
      tag_q[idx]  <= tag;
      line_q[idx] <= fill_line;
    end else if (wr_en) begin
      line_q[idx][lookup_word] <= wr_data;
    end
  end

  // stores reach the array only once the block is resident
  a_wr_hits: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    wr_en |-> arr_hit);

endmodule

// ==== hdl/l1d_mshr_file.sv ====
/*
  l1d MSHR file: one entry per outstanding block, each with a small
  circular queue of the requests waiting on that block
*/
`timescale 1ns/10ps

module l1d_mshr_file import l1d_pkg::*; (
  input  logic        clk_in,
  input  logic        rst_N_in,
  input  block_addr_t lookup_addr,
  input  logic        push_en,
  input  mshr_op_t    push_op,
  input  logic        pop_en,
  output logic        mshr_match,
  output logic        mshr_match_full,
  output logic        mshr_free,
  output mshr_op_t    mshr_head,
  output logic        mshr_head_valid
);

  logic [MSHR_COUNT-1:0]    valid_q;
  block_addr_t              blk_q [MSHR_COUNT];
  logic [MSHR_PTR_BITS-1:0] rd_ptr_q [MSHR_COUNT];
  logic [MSHR_PTR_BITS-1:0] wr_ptr_q [MSHR_COUNT];
  logic [MSHR_CNT_BITS-1:0] count_q [MSHR_COUNT];
  mshr_op_t                 queue_q [MSHR_COUNT][MSHR_DEPTH];

  logic [MSHR_IDX_BITS-1:0] match_idx;
  logic [MSHR_IDX_BITS-1:0] free_idx;
  logic [MSHR_IDX_BITS-1:0] push_idx;

  // block address match and lowest free entry
  always_comb begin
    mshr_match = 1'b0;
    match_idx  = '0;
    mshr_free  = 1'b0;
    free_idx   = '0;
    for (int i = MSHR_COUNT - 1; i >= 0; i--) begin
      if (valid_q[i] && (blk_q[i] == lookup_addr)) begin
        mshr_match = 1'b1;
        match_idx  = MSHR_IDX_BITS'(i);
      end
      if (!valid_q[i]) begin
        mshr_free = 1'b1;
        free_idx  = MSHR_IDX_BITS'(i);
      end
    end
  end

  // a push joins the matching entry, otherwise it opens a free one
  assign push_idx = mshr_match ? match_idx : free_idx;

  assign mshr_match_full = mshr_match && (count_q[match_idx] == MSHR_CNT_BITS'(MSHR_DEPTH));
  assign mshr_head_valid = mshr_match && (count_q[match_idx] != '0);
  assign mshr_head       = queue_q[match_idx][rd_ptr_q[match_idx]];

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      valid_q <= '0;
      for (int i = 0; i < MSHR_COUNT; i++) begin
        rd_ptr_q[i] <= '0;
        wr_ptr_q[i] <= '0;
        count_q[i]  <= '0;
      end
    end else begin
      if (push_en) begin
        valid_q[push_idx]  <= 1'b1;
        wr_ptr_q[push_idx] <= wr_ptr_q[push_idx] + 1'b1;
        count_q[push_idx]  <= count_q[push_idx] + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q[match_idx] <= rd_ptr_q[match_idx] + 1'b1;
        count_q[match_idx]  <= count_q[match_idx] - 1'b1;
        // last waiter gone, entry becomes free
        if (count_q[match_idx] == MSHR_CNT_BITS'(1)) begin
          valid_q[match_idx] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (push_en) begin
      queue_q[push_idx][wr_ptr_q[push_idx]] <= push_op;
      if (!mshr_match) blk_q[push_idx] <= lookup_addr;
    end
  end

  // a push always has somewhere to land
  a_push_room: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    push_en |-> (mshr_match && !mshr_match_full) || (!mshr_match && mshr_free));

  a_pop_nonempty: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    pop_en |-> mshr_head_valid);

endmodule

// ==== hdl/l1d_pkg.sv ====
/*
  l1d shared definitions: cache geometry, address fields and the
  packed request/response structs used on the LSU and lower-level ports
*/
package l1d_pkg;

  localparam int PADDR_BITS     = 16;
  localparam int WORD_BITS      = 64;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_BITS      = WORD_BITS * WORDS_PER_LINE;
  localparam int OFFSET_BITS    = 5;
  localparam int BYTE_OFF_BITS  = $clog2(WORD_BITS / 8);
  localparam int WORD_OFF_BITS  = $clog2(WORDS_PER_LINE);
  localparam int NUM_SETS       = 16;
  localparam int INDEX_BITS     = $clog2(NUM_SETS);
  localparam int TAG_BITS       = PADDR_BITS - OFFSET_BITS - INDEX_BITS;
  localparam int LSU_TAG_BITS   = 6;

  localparam int MSHR_COUNT     = 2;
  localparam int MSHR_DEPTH     = 4;
  localparam int MSHR_IDX_BITS  = $clog2(MSHR_COUNT);
  localparam int MSHR_PTR_BITS  = $clog2(MSHR_DEPTH);
  localparam int MSHR_CNT_BITS  = $clog2(MSHR_DEPTH + 1);

  typedef logic [PADDR_BITS-OFFSET_BITS-1:0] block_addr_t;
  typedef logic [WORD_OFF_BITS-1:0]          word_sel_t;

  typedef struct packed {
    logic [LSU_TAG_BITS-1:0] tag;
    logic [PADDR_BITS-1:0]   addr;
    logic                    we;
    logic [WORD_BITS-1:0]    data;
  } lsu_req_t;

  // data is zero for write acknowledgements
  typedef struct packed {
    logic [LSU_TAG_BITS-1:0] tag;
    logic                    we;
    logic [WORD_BITS-1:0]    data;
  } lsu_rsp_t;

  typedef struct packed {
    block_addr_t          addr;
    logic                 we;
    logic [LINE_BITS-1:0] line;
  } lc_req_t;

  typedef struct packed {
    block_addr_t          addr;
    logic [LINE_BITS-1:0] line;
  } lc_rsp_t;

  // one request parked behind an outstanding block
  typedef struct packed {
    logic [LSU_TAG_BITS-1:0] tag;
    word_sel_t               word;
    logic                    we;
    logic [WORD_BITS-1:0]    data;
  } mshr_op_t;

  typedef enum logic [2:0] {
    IDLE,
    RESPOND,
    REQ_LINE,
    WRITEBACK,
    REPLAY,
    REPLAY_RESPOND
  } ctrl_state_t;

  function automatic block_addr_t blk_of(logic [PADDR_BITS-1:0] addr);
    return addr[PADDR_BITS-1:OFFSET_BITS];
  endfunction

  function automatic word_sel_t word_of(logic [PADDR_BITS-1:0] addr);
    return addr[OFFSET_BITS-1:BYTE_OFF_BITS];
  endfunction

endpackage

// ==== hdl/l1d_top.sv ====
/*
  l1d top: non-blocking write-back L1 data cache built from the
  controller FSM, the direct-mapped array and the MSHR file
*/
`timescale 1ns/10ps

module l1d_top import l1d_pkg::*; (
  input  logic     clk_in,
  input  logic     rst_N_in,
  // LSU side
  input  lsu_req_t lsu_req,
  input  logic     lsu_req_valid,
  output logic     lsu_req_ready,
  output lsu_rsp_t lsu_rsp,
  output logic     lsu_rsp_valid,
  input  logic     lsu_rsp_ready,
  // lower level side
  output lc_req_t  lc_req,
  output logic     lc_req_valid,
  input  logic     lc_req_ready,
  input  lc_rsp_t  lc_rsp,
  input  logic     lc_rsp_valid,
  output logic     lc_rsp_ready
);

  // shared lookup, driven by the controller
  block_addr_t          lookup_addr;
  word_sel_t            lookup_word;

  // array links
  logic                 arr_hit;
  logic [WORD_BITS-1:0] arr_word;
  logic                 wr_en;
  logic [WORD_BITS-1:0] wr_data;
  logic                 fill_en;
  logic [LINE_BITS-1:0] fill_line;
  logic                 victim_valid_dirty;
  block_addr_t          victim_addr;
  logic [LINE_BITS-1:0] victim_line;

  // MSHR links
  logic                 mshr_match;
  logic                 mshr_match_full;
  logic                 mshr_free;
  mshr_op_t             mshr_head;
  logic                 mshr_head_valid;
  logic                 push_en;
  mshr_op_t             push_op;
  logic                 pop_en;

  l1d_ctrl u_l1d_ctrl (
    .*
  );

  l1d_data_array u_l1d_data_array (
    .*
  );

  l1d_mshr_file u_l1d_mshr_file (
    .*
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the l1d testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_l1d -o tb_l1d

out=$(./obj_dir/tb_l1d)
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1

// ==== sim.f ====
hdl/l1d_pkg.sv
hdl/l1d_data_array.sv
hdl/l1d_mshr_file.sv
hdl/l1d_ctrl.sv
hdl/l1d_top.sv
testbench/tb_clk_gen.sv
testbench/tb_lower_mem.sv
testbench/tb_l1d.sv

// ==== testbench/tb_clk_gen.sv ====
/*
  testbench clock and reset source, reset held low for a few cycles
*/
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_in,
  output logic rst_N_in
);

  initial begin
    clk_in = 1'b0;
    forever #(PERIOD / 2) clk_in = ~clk_in;
  end

  initial begin
    rst_N_in = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_in);
    @(negedge clk_in);
    rst_N_in = 1'b1;
  end

endmodule

// ==== testbench/tb_l1d.sv ====
/*
  l1d testbench: applies a table of LSU requests, scores responses by
  tag against a model memory and watches the lower-level traffic
*/
`timescale 1ns/10ps

module tb_l1d import l1d_pkg::*; ();

  localparam logic [WORD_BITS-1:0] PATTERN = 64'h5a5a_c3c3_0f0f_9696;

  typedef struct {
    int                   gap;
    logic                 we;
    logic [PADDR_BITS-1:0] addr;
    logic [WORD_BITS-1:0] data;
    bit                   hit;
    bit                   fetch;
    int                   later;
  } row_t;

  logic clk_in;
  logic rst_N_in;
  lsu_req_t lsu_req;
  logic     lsu_req_valid;
  logic     lsu_req_ready;
  lsu_rsp_t lsu_rsp;
  logic     lsu_rsp_valid;
  logic     lsu_rsp_ready;
  lc_req_t  lc_req;
  logic     lc_req_valid;
  logic     lc_req_ready;
  lc_rsp_t  lc_rsp;
  logic     lc_rsp_valid;
  logic     lc_rsp_ready;

  row_t                 rows [$];
  logic [WORD_BITS-1:0] model [int];
  logic [WORD_BITS-1:0] exp_data [64];
  bit                   pending [64];
  int                   accept_cyc [64];
  int                   first_seen [64];
  int                   arr_seq [64];
  block_addr_t          fetch_blk [$];
  int cycle = 0;
  int limit = 0;
  int outstanding = 0;
  int seq = 0;
  int fetches = 0;
  int checks = 0;
  int errors = 0;
  int done_tests = 0;
  bit       stall_prev = 1'b0;
  lsu_rsp_t held;

  tb_clk_gen u_tb_clk_gen (.clk_in(clk_in), .rst_N_in(rst_N_in));

  tb_lower_mem #(.PATTERN(PATTERN)) u_tb_lower_mem (.*);

  l1d_top u_l1d_top (.*);

  task automatic check(string name, logic [63:0] got, logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic [WORD_BITS-1:0] model_read(int key);
    return model.exists(key) ? model[key] : (64'(key) ^ PATTERN);
  endfunction

  task automatic add_row(int gap, logic we, logic [15:0] addr, logic [63:0] data,
                         bit hit, bit fetch, int later);
    row_t r;
    r = '{gap: gap, we: we, addr: addr, data: data, hit: hit, fetch: fetch, later: later};
    rows.push_back(r);
  endtask

  // block A at 0x0020, C at 0x0040, D at 0x0060, E at 0x0220 shares A's set
  task automatic build_table();
    add_row(0,  1'b0, 16'h0020, 64'h0, 1'b0, 1'b1, -1);
    add_row(40, 1'b0, 16'h0028, 64'h0, 1'b1, 1'b0, -1);
    add_row(0,  1'b1, 16'h0028, 64'h1111_2222_3333_4444, 1'b1, 1'b0, -1);
    add_row(0,  1'b0, 16'h0028, 64'h0, 1'b1, 1'b0, -1);
    // four requests pile up behind one pending block
    add_row(2,  1'b0, 16'h0040, 64'h0, 1'b0, 1'b1, 5);
    add_row(0,  1'b1, 16'h0048, 64'hdead_beef_0000_0001, 1'b0, 1'b0, 6);
    add_row(0,  1'b0, 16'h0048, 64'h0, 1'b0, 1'b0, 7);
    add_row(0,  1'b1, 16'h0040, 64'hcafe_f00d_0000_0002, 1'b0, 1'b0, -1);
    // hit overtakes a pending miss
    add_row(40, 1'b0, 16'h0060, 64'h0, 1'b0, 1'b1, -1);
    add_row(0,  1'b0, 16'h0020, 64'h0, 1'b1, 1'b0, 8);
    // dirty A is pushed out by E and fetched again
    add_row(40, 1'b1, 16'h0030, 64'h0123_4567_89ab_cdef, 1'b1, 1'b0, -1);
    add_row(0,  1'b1, 16'h0038, 64'hfedc_ba98_7654_3210, 1'b1, 1'b0, -1);
    add_row(0,  1'b0, 16'h0220, 64'h0, 1'b0, 1'b1, -1);
    add_row(40, 1'b0, 16'h0030, 64'h0, 1'b0, 1'b1, 14);
    add_row(0,  1'b0, 16'h0038, 64'h0, 1'b0, 1'b0, 15);
    add_row(0,  1'b0, 16'h0028, 64'h0, 1'b0, 1'b0, -1);
    add_row(40, 1'b1, 16'h0068, 64'h7777_8888_9999_aaaa, 1'b1, 1'b0, -1);
    add_row(0,  1'b0, 16'h0068, 64'h0, 1'b1, 1'b0, -1);
    add_row(0,  1'b0, 16'h0060, 64'h0, 1'b1, 1'b0, -1);
  endtask

  task automatic accept(int i);
    int key;
    key = int'(rows[i].addr[PADDR_BITS-1:BYTE_OFF_BITS]);
    accept_cyc[i] = cycle;
    first_seen[i] = -1;
    pending[i]    = 1'b1;
    outstanding++;
    // a primary miss must ask for exactly its own block
    if (rows[i].fetch) fetch_blk.push_back(rows[i].addr[PADDR_BITS-1:OFFSET_BITS]);
    if (rows[i].we) begin
      model[key]  = rows[i].data;
      exp_data[i] = '0;
    end else begin
      exp_data[i] = model_read(key);
    end
  endtask

  always @(posedge clk_in) begin
    cycle <= cycle + 1;
    if (limit > 0 && cycle >= limit) begin
      $display("timeout after %0d cycles with %0d responses outstanding", cycle, outstanding);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // response scoreboard
  always @(posedge clk_in) begin : rsp_monitor
    int t;
    t = int'(lsu_rsp.tag);
    if (rst_N_in) begin
      if (lsu_rsp_valid && pending[t] && first_seen[t] < 0) first_seen[t] = cycle;
      if (stall_prev) begin
        check("lsu_rsp_valid", 64'(lsu_rsp_valid), 64'(1));
        check("lsu_rsp.tag", 64'(lsu_rsp.tag), 64'(held.tag));
        check("lsu_rsp.we", 64'(lsu_rsp.we), 64'(held.we));
        check("lsu_rsp.data", lsu_rsp.data, held.data);
      end
      stall_prev = lsu_rsp_valid && !lsu_rsp_ready;
      held       = lsu_rsp;
      if (lsu_rsp_valid && lsu_rsp_ready) begin
        if (!pending[t]) begin
          errors++;
          $display("response with tag %0d was not expected or came twice", t);
        end else begin
          pending[t] = 1'b0;
          outstanding--;
          arr_seq[t] = seq++;
          check("lsu_rsp.we", 64'(lsu_rsp.we), 64'(rows[t].we));
          check("lsu_rsp.data", lsu_rsp.data, exp_data[t]);
          if (rows[t].hit) check("hit latency", 64'(first_seen[t] - accept_cyc[t]), 64'(1));
          done_tests++;
          $display("test %0d addr %h %s done", t, rows[t].addr, rows[t].we ? "write" : "read");
        end
      end
      if (lc_req_valid && lc_req_ready) begin
        if (lc_req.we) begin
          for (int w = 0; w < WORDS_PER_LINE; w++) begin
            check("lc_req.line", lc_req.line[w*WORD_BITS +: WORD_BITS],
                  model_read(int'(lc_req.addr) * WORDS_PER_LINE + w));
          end
        end else begin
          fetches++;
          if (fetch_blk.size() == 0) begin
            errors++;
            $display("lower read request for block %h was not expected", lc_req.addr);
          end else begin
            check("lc_req.addr", 64'(lc_req.addr), 64'(fetch_blk.pop_front()));
          end
        end
      end
    end
  end

  initial begin
    int exp_fetches;
    lsu_req       = '0;
    lsu_req_valid = 1'b0;
    exp_fetches   = 0;
    build_table();
    limit = rows.size() * 80;
    wait (rst_N_in === 1'b1);
    @(negedge clk_in);
    check("lsu_rsp_valid", 64'(lsu_rsp_valid), 64'(0));
    check("lc_req_valid", 64'(lc_req_valid), 64'(0));
    check("lsu_req_ready", 64'(lsu_req_ready), 64'(0));
    check("lc_rsp_ready", 64'(lc_rsp_ready), 64'(0));
    for (int i = 0; i < rows.size(); i++) begin
      repeat (rows[i].gap) @(negedge clk_in);
      lsu_req = '{tag: LSU_TAG_BITS'(i), addr: rows[i].addr, we: rows[i].we,
                  data: rows[i].data};
      lsu_req_valid = 1'b1;
      do @(posedge clk_in); while (!lsu_req_ready);
      accept(i);
      if (rows[i].fetch) exp_fetches++;
      @(negedge clk_in);
      lsu_req_valid = 1'b0;
    end
    wait (outstanding == 0);
    repeat (4) @(negedge clk_in);
    check("lower read count", 64'(fetches), 64'(exp_fetches));
    for (int i = 0; i < rows.size(); i++) begin
      if (rows[i].later >= 0 && arr_seq[i] >= arr_seq[rows[i].later]) begin
        errors++;
        $display("test %0d answered after test %0d, out of order", i, rows[i].later);
      end
    end
    $display("tests %0d/%0d, checks %0d, errors %0d", done_tests, rows.size(), checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== testbench/tb_lower_mem.sv ====
/*
  lower-level memory model: answers refills after a random delay,
  absorbs write-backs and stalls the LSU response side at random
*/
`timescale 1ns/10ps

module tb_lower_mem import l1d_pkg::*; #(
  parameter logic [WORD_BITS-1:0] PATTERN = 64'h0
) (
  input  logic    clk_in,
  input  logic    rst_N_in,
  input  lc_req_t lc_req,
  input  logic    lc_req_valid,
  output logic    lc_req_ready,
  output lc_rsp_t lc_rsp,
  output logic    lc_rsp_valid,
  input  logic    lc_rsp_ready,
  output logic    lsu_rsp_ready
);

  logic [WORD_BITS-1:0] mem [int];
  block_addr_t          rd_blk [$];
  int                   rd_due [$];
  logic [31:0]          rng = 32'd63203;
  int                   cyc = 0;

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // untouched words hold their word address mixed with the pattern
  function automatic logic [WORD_BITS-1:0] word_at(int a);
    return mem.exists(a) ? mem[a] : (64'(a) ^ PATTERN);
  endfunction

  initial begin
    lc_req_ready  = 1'b0;
    lc_rsp        = '0;
    lc_rsp_valid  = 1'b0;
    lsu_rsp_ready = 1'b0;
  end

  always @(posedge clk_in) begin
    cyc = cyc + 1;
    rng = xorshift32(rng);
    if (rst_N_in && lc_req_valid && lc_req_ready) begin
      if (lc_req.we) begin
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
          mem[int'(lc_req.addr) * WORDS_PER_LINE + w] = lc_req.line[w*WORD_BITS +: WORD_BITS];
        end
      end else begin
        rd_blk.push_back(lc_req.addr);
        rd_due.push_back(cyc + 10 + int'(rng % 32'd21));
      end
    end
    if (rst_N_in && lc_rsp_valid && lc_rsp_ready) begin
      void'(rd_blk.pop_front());
      void'(rd_due.pop_front());
    end
  end

  always @(negedge clk_in) begin
    rng = xorshift32(rng);
    lc_req_ready  = rst_N_in;
    lsu_rsp_ready = rst_N_in && (rng[1:0] != 2'b00);
    lc_rsp_valid  = 1'b0;
    if (rst_N_in && rd_blk.size() > 0 && cyc >= rd_due[0]) begin
      lc_rsp.addr = rd_blk[0];
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        lc_rsp.line[w*WORD_BITS +: WORD_BITS] = word_at(int'(rd_blk[0]) * WORDS_PER_LINE + w);
      end
      lc_rsp_valid = 1'b1;
    end
  end

endmodule
